// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_openadc_capture
FILELIST = verilog.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_openadc_capture.sv
module tb_openadc_capture;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int    N_CAPTURES  = 14;
   localparam int    CLK_PERIOD  = 10;
   localparam longint WATCHDOG_NS = longint'(N_CAPTURES) * 300 * 256 * CLK_PERIOD;

   logic                      ADC_clk_sample;
   logic                      reset;
   logic [11:0]               adc_data_i;
   logic                      ext_trigger_i;
   logic [7:0]                reg_address_i;
   logic [7:0]                reg_datai_i;
   logic                      reg_write_i;
   logic                      reg_read_i;
   logic [7:0]                reg_datao_o;
   adc_capture_pkg::rd_byte_t rd_data_o;
   logic                      rd_valid_o;
   logic                      rd_ready_i;

   int                        stim_mode;    // 0 idle, 1 ramp, 2 random with ext = bit 11
   logic                      ext_level;
   logic [11:0]               ramp;
   adc_capture_pkg::rd_byte_t rx_q[$];
   logic [11:0]               samp[$];

   openadc_capture_top openadc_capture_top_inst (.*);

   initial begin
      ADC_clk_sample = 1'b0;
      forever #(CLK_PERIOD / 2) ADC_clk_sample = ~ADC_clk_sample;
   end

   // ADC pin and trigger pin stimulus
   always @(posedge ADC_clk_sample) begin
      #1;
      case (stim_mode)
         1: begin
            if (ramp < 12'd4090)
               ramp = ramp + 12'($urandom_range(0, 2));
            adc_data_i    = ramp;
            ext_trigger_i = 1'b0;
         end
         2: begin
            adc_data_i    = 12'($urandom);
            ext_trigger_i = adc_data_i[11];   // Pin and sample bit move together
         end
         default: begin
            ramp          = '0;
            adc_data_i    = '0;
            ext_trigger_i = ext_level;
         end
      endcase
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the capture tests did not finish in the allowed time");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input adc_capture_pkg::rd_byte_t exp,
                             input adc_capture_pkg::rd_byte_t got, input string name);
      if (got !== exp)
         fail_run($sformatf("Mismatch at %0t: %s got data %h last %b, expected data %h last %b",
                            $time, name, got.data, got.last, exp.data, exp.last));
   endtask

   task automatic check_status(input adc_capture_pkg::status_t exp,
                               input adc_capture_pkg::status_t got);
      if (got !== exp)
         fail_run($sformatf("Mismatch at %0t: status got %b expected %b", $time, got, exp));
   endtask

   task automatic check_reg(input logic [7:0] exp, input logic [7:0] got, input string name);
      if (got !== exp)
         fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_count(input int exp, input int got, input string name);
      if (got != exp)
         fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge ADC_clk_sample);
      #1;
      reg_address_i = addr;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(posedge ADC_clk_sample);
      #1;
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      @(posedge ADC_clk_sample);
      #1;
      reg_address_i = addr;
      reg_read_i    = 1'b1;
      @(posedge ADC_clk_sample);
      #1;
      reg_read_i    = 1'b0;
      data          = reg_datao_o;   // Registered one cycle after the strobe
   endtask

   function automatic logic [7:0] make_ctrl(input logic ext, input logic high,
                                            input logic adc, input logic low_res);
      adc_capture_pkg::ctrl_reg_t c;
      c           = '0;
      c.arm       = 1'b1;
      c.trig_ext  = ext;
      c.trig_high = high;
      c.src_adc   = adc;
      c.low_res   = low_res;
      return c;
   endfunction

   task automatic arm_capture(input logic [7:0] ctrl, input logic [11:0] level,
                              input int pre, input int max, input int ds);
      write_reg(adc_capture_pkg::REG_LEVEL_LO, level[7:0]);
      write_reg(adc_capture_pkg::REG_LEVEL_HI, {4'h0, level[11:8]});
      write_reg(adc_capture_pkg::REG_PRESAMPLES, 8'(pre));
      write_reg(adc_capture_pkg::REG_MAXSAMPLES, 8'(max));
      write_reg(adc_capture_pkg::REG_DOWNSAMPLE, 8'(ds));
      write_reg(adc_capture_pkg::REG_CTRL, ctrl);
      repeat (3) @(posedge ADC_clk_sample);   // Let an old window clear out
      #1;
   endtask

   // Collects one window; ready_pct sets how often rd_ready_i is high
   task automatic drain_window(input int ready_pct);
      adc_capture_pkg::rd_byte_t held;
      logic was_stalled;
      logic done;
      rx_q.delete();
      was_stalled = 1'b0;
      done        = 1'b0;
      held        = '0;
      while (!done) begin
         @(posedge ADC_clk_sample);
         #1;
         if (was_stalled) begin
            if (rd_valid_o !== 1'b1)
               fail_run("rd_valid_o dropped while the byte was not yet accepted");
            check_byte(held, rd_data_o, "rd_data_o under back-pressure");
         end
         rd_ready_i = ($urandom_range(0, 99) < ready_pct);
         if (rd_valid_o && rd_ready_i) begin
            rx_q.push_back(rd_data_o);
            done = rd_data_o.last;
         end
         was_stalled = rd_valid_o && !rd_ready_i;
         held        = rd_data_o;
      end
      @(posedge ADC_clk_sample);
      #1;
      rd_ready_i = 1'b0;
   endtask

   task automatic check_window(input int n_bytes);
      adc_capture_pkg::rd_byte_t exp;
      check_count(n_bytes, rx_q.size(), "byte count");
      for (int i = 0; i < n_bytes; i++) begin
         exp      = rx_q[i];
         exp.last = (i == n_bytes - 1);
         check_byte(exp, rx_q[i], "rd_data_o.last");
      end
   endtask

   function automatic void samples_from_full();
      samp.delete();
      for (int k = 0; k < rx_q.size() / 2; k++)
         samp.push_back({rx_q[2*k].data[3:0], rx_q[2*k+1].data});
   endfunction

   initial begin
      adc_capture_pkg::rd_byte_t exp;
      logic [7:0]  rd;
      logic [7:0]  v;
      logic [11:0] s0;
      logic [11:0] pred;
      logic        high;
      logic        found;
      int          max;
      int          n;
      int          pre;
      int          ds;
      int          level;
      int          polls;

      void'($urandom(32'h6c81b18c));
      stim_mode     = 0;
      ext_level     = 1'b0;
      ramp          = '0;
      adc_data_i    = '0;
      ext_trigger_i = 1'b0;
      reg_address_i = '0;
      reg_datai_i   = '0;
      reg_write_i   = 1'b0;
      reg_read_i    = 1'b0;
      rd_ready_i    = 1'b0;
      reset         = 1'b1;
      repeat (4) @(posedge ADC_clk_sample);
      #1;
      reset = 1'b0;

      // Register readback
      read_reg(adc_capture_pkg::REG_STATUS, rd);
      check_status('0, rd);
      v = 8'($urandom);
      write_reg(adc_capture_pkg::REG_LEVEL_LO, v);
      read_reg(adc_capture_pkg::REG_LEVEL_LO, rd);
      check_reg(v, rd, "REG_LEVEL_LO");
      v = 8'($urandom);
      write_reg(adc_capture_pkg::REG_LEVEL_HI, v);
      read_reg(adc_capture_pkg::REG_LEVEL_HI, rd);
      check_reg(v & 8'h0f, rd, "REG_LEVEL_HI");
      v = 8'($urandom);
      write_reg(adc_capture_pkg::REG_PRESAMPLES, v);
      read_reg(adc_capture_pkg::REG_PRESAMPLES, rd);
      check_reg(v, rd, "REG_PRESAMPLES");
      v = 8'($urandom);
      write_reg(adc_capture_pkg::REG_MAXSAMPLES, v);
      read_reg(adc_capture_pkg::REG_MAXSAMPLES, rd);
      check_reg(v, rd, "REG_MAXSAMPLES");
      v = 8'($urandom);
      write_reg(adc_capture_pkg::REG_DOWNSAMPLE, v);
      read_reg(adc_capture_pkg::REG_DOWNSAMPLE, rd);
      check_reg(v, rd, "REG_DOWNSAMPLE");
      v = 8'($urandom) | 8'h01;
      write_reg(adc_capture_pkg::REG_CTRL, v);
      read_reg(adc_capture_pkg::REG_CTRL, rd);
      check_reg(v & 8'h1e, rd, "REG_CTRL");   // Arm and reserved bits read zero

      // Counter source, full mode, first window at 256 samples
      for (int it = 0; it < 3; it++) begin
         max = (it == 0) ? 0 : $urandom_range(16, 64);
         n   = (max == 0) ? 256 : max;
         pre = $urandom_range(0, n - 1);
         ds  = $urandom_range(0, 7);
         arm_capture(make_ctrl(1'b0, 1'b1, 1'b0, 1'b0), 12'h000, pre, max, ds);
         drain_window(75);
         check_window(2 * n);
         s0 = {rx_q[0].data[3:0], rx_q[1].data};
         for (int k = 0; k < n; k++) begin
            pred = s0 + 12'(k * (ds + 1));
            exp.data = {4'h0, pred[11:8]};
            exp.last = 1'b0;
            check_byte(exp, rx_q[2*k], "rd_data_o hi byte");
            exp.data = pred[7:0];
            exp.last = (k == n - 1);
            check_byte(exp, rx_q[2*k+1], "rd_data_o lo byte");
         end
      end

      // Level trigger on a rising ramp
      for (int it = 0; it < 3; it++) begin
         max   = $urandom_range(16, 64);
         pre   = $urandom_range(1, max - 1);
         ds    = $urandom_range(0, 3);
         level = $urandom_range(1000, 3000);
         stim_mode = 1;
         arm_capture(make_ctrl(1'b0, 1'b1, 1'b1, 1'b0), 12'(level), pre, max, ds);
         drain_window(75);
         stim_mode = 0;
         check_window(2 * max);
         samples_from_full();
         if (samp[pre] < 12'(level))
            fail_run("trigger sample is below the level threshold");
         if (samp[pre-1] >= 12'(level))
            fail_run("sample before the trigger sample already met the level rule");
         for (int k = 1; k < max; k++)
            if (samp[k] < samp[k-1])
               fail_run("captured ramp is not rising");
      end

      // External trigger, pin tied to ADC bit 11
      for (int it = 0; it < 3; it++) begin
         max  = $urandom_range(16, 64);
         pre  = $urandom_range(0, max - 1);
         ds   = $urandom_range(0, 3);
         high = 1'($urandom);
         stim_mode = 2;
         arm_capture(make_ctrl(1'b1, high, 1'b1, 1'b0), 12'h000, pre, max, ds);
         drain_window(75);
         stim_mode = 0;
         check_window(2 * max);
         samples_from_full();
         if (samp[pre][11] !== high)
            fail_run("trigger sample bit 11 does not match the trigger polarity");
      end

      // Low-res counter readout under heavy back-pressure
      for (int it = 0; it < 3; it++) begin
         max = $urandom_range(16, 64);
         pre = $urandom_range(0, max - 1);
         ds  = $urandom_range(0, 15);
         arm_capture(make_ctrl(1'b0, 1'b1, 1'b0, 1'b1), 12'h000, pre, max, ds);
         drain_window(40);
         check_window(max);
         found = 1'b0;
         for (int lo = 0; lo < 16 && !found; lo++) begin
            s0    = {rx_q[0].data, 4'(lo)};   // Low nibble is not visible in low-res
            found = 1'b1;
            for (int k = 0; k < max; k++) begin
               pred = s0 + 12'(k * (ds + 1));
               if (pred[11:4] != rx_q[k].data)
                  found = 1'b0;
            end
         end
         if (!found)
            fail_run("low-res bytes do not follow any counter sequence");
      end

      // Status through one capture
      ext_level = 1'b0;
      arm_capture(make_ctrl(1'b1, 1'b1, 1'b0, 1'b0), 12'h000, 4, 16, 0);
      read_reg(adc_capture_pkg::REG_STATUS, rd);
      check_status(8'h01, rd);
      ext_level = 1'b1;
      polls     = 0;
      do begin
         read_reg(adc_capture_pkg::REG_STATUS, rd);
         polls++;
      end while (!rd[2] && polls < 200);
      if (!rd[2])
         fail_run("data_ready never rose after the external trigger was applied");
      check_status(8'h06, rd);
      ext_level = 1'b0;
      drain_window(75);
      check_window(32);
      read_reg(adc_capture_pkg::REG_STATUS, rd);
      check_status(8'h02, rd);

      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: verilog.f
verilog/adc_capture_pkg.sv
verilog/adc_reg_block.sv
verilog/adc_sample_source.sv
verilog/adc_trigger_unit.sv
verilog/adc_capture_buffer.sv
verilog/adc_readout.sv
verilog/openadc_capture_top.sv
verification/tb_openadc_capture.sv

// File: verilog/adc_capture_buffer.sv
module adc_capture_buffer (
   input  logic                                 ADC_clk_sample,
   input  logic                                 reset,
   input  adc_capture_pkg::capture_cfg_t        cfg_i,
   input  logic                                 arm_i,
   input  logic                                 strobe_i,
   input  logic [adc_capture_pkg::SAMPLE_W-1:0] sample_i,
   input  logic                                 record_i,
   input  logic                                 trig_hit_i,
   input  logic                                 next_sample_i,
   input  logic                                 rd_done_i,
   output logic                                 capture_done_o,
   output logic                                 data_ready_o,
   output adc_capture_pkg::sample_u             sample_o,
   output logic                                 sample_valid_o
);

   logic [adc_capture_pkg::SAMPLE_W-1:0] mem [adc_capture_pkg::BUF_DEPTH];
   logic [adc_capture_pkg::BUF_AW-1:0]   wr_ptr;
   logic [adc_capture_pkg::BUF_AW-1:0]   rd_ptr;
   logic [adc_capture_pkg::BUF_AW-1:0]   win_start;
   logic [adc_capture_pkg::BUF_AW:0]     total;
   logic [adc_capture_pkg::BUF_AW:0]     post_len;
   logic [adc_capture_pkg::BUF_AW:0]     post_cnt;
   logic                                 post_active;
   logic                                 wr_en;

   assign total = (cfg_i.maxsamples == '0) ?
                  (adc_capture_pkg::BUF_AW+1)'(adc_capture_pkg::BUF_DEPTH) :
                  {1'b0, cfg_i.maxsamples};
   assign post_len  = total - {1'b0, cfg_i.presamples} - 1'b1;   // After the trigger sample
   assign win_start = wr_ptr - cfg_i.presamples;                 // wr_ptr points at trigger
   assign wr_en     = record_i && strobe_i;

   // Done with the last write, so record drops before another strobe lands
   assign capture_done_o = (trig_hit_i && post_len == '0) ||
                           (post_active && wr_en && post_cnt == 1);

   always_ff @(posedge ADC_clk_sample) begin
      if (wr_en)
         mem[wr_ptr] <= sample_i;
      if (next_sample_i) begin
         sample_o.full.pad   <= '0;
         sample_o.full.value <= mem[rd_ptr];
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         post_cnt       <= '0;
         post_active    <= 1'b0;
         data_ready_o   <= 1'b0;
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= next_sample_i;
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;

         if (arm_i) begin
            post_active  <= 1'b0;
            data_ready_o <= 1'b0;   // Old window is dropped
         end else begin
            if (trig_hit_i && post_len != '0) begin
               post_active <= 1'b1;
               post_cnt    <= post_len;
            end else if (post_active && wr_en) begin
               post_cnt <= post_cnt - 1'b1;
               if (post_cnt == 1)
                  post_active <= 1'b0;
            end
            if (capture_done_o)
               data_ready_o <= 1'b1;
            else if (rd_done_i)
               data_ready_o <= 1'b0;
         end

         // Replay starts at the window start
         if (trig_hit_i)
            rd_ptr <= win_start;
         else if (next_sample_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

// File: verilog/adc_capture_pkg.sv
package adc_capture_pkg;

   localparam int SAMPLE_W  = 12;
   localparam int BUF_DEPTH = 256;
   localparam int BUF_AW    = 8;

   // Register map
   localparam logic [7:0] REG_CTRL       = 8'd0;
   localparam logic [7:0] REG_STATUS     = 8'd1;
   localparam logic [7:0] REG_LEVEL_LO   = 8'd2;
   localparam logic [7:0] REG_LEVEL_HI   = 8'd3;
   localparam logic [7:0] REG_PRESAMPLES = 8'd4;
   localparam logic [7:0] REG_MAXSAMPLES = 8'd5;
   localparam logic [7:0] REG_DOWNSAMPLE = 8'd6;

   typedef struct packed {
      logic [2:0] reserved;   // Read as zero
      logic       low_res;    // One byte per sample on readout
      logic       src_adc;    // 1 = ADC pins, 0 = test counter
      logic       trig_high;  // Trigger polarity
      logic       trig_ext;   // 1 = external pin, 0 = analog level
      logic       arm;        // Write 1 to arm, never stored
   } ctrl_reg_t;

   typedef struct packed {
      ctrl_reg_t            ctrl;
      logic [SAMPLE_W-1:0]  level;
      logic [7:0]           presamples;
      logic [7:0]           maxsamples;   // 0 stands for 256
      logic [7:0]           downsample;
   } capture_cfg_t;

   typedef struct packed {
      logic [4:0] zero;
      logic       data_ready;
      logic       triggered;
      logic       armed;
   } status_t;

   // Readout word, taken either as a sample or as two bytes
   typedef union packed {
      struct packed {
         logic [3:0]          pad;
         logic [SAMPLE_W-1:0] value;
      } full;
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
   } sample_u;

   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } rd_byte_t;

endpackage

// File: verilog/adc_readout.sv
module adc_readout (
   input  logic                          ADC_clk_sample,
   input  logic                          reset,
   input  adc_capture_pkg::capture_cfg_t cfg_i,
   input  logic                          data_ready_i,
   input  adc_capture_pkg::sample_u      sample_i,
   input  logic                          sample_valid_i,
   input  logic                          rd_ready_i,
   output logic                          next_sample_o,
   output logic                          rd_done_o,
   output adc_capture_pkg::rd_byte_t     rd_data_o,
   output logic                          rd_valid_o
);

   logic [adc_capture_pkg::BUF_AW:0] total;
   logic [adc_capture_pkg::BUF_AW:0] rem;   // Samples still to fetch
   logic                             active;
   logic                             pend_lo;
   logic [7:0]                       lo_q;
   logic                             accept;

   assign total = (cfg_i.maxsamples == '0) ?
                  (adc_capture_pkg::BUF_AW+1)'(adc_capture_pkg::BUF_DEPTH) :
                  {1'b0, cfg_i.maxsamples};
   assign accept    = rd_valid_o && rd_ready_i;
   assign rd_done_o = accept && rd_data_o.last;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         active        <= 1'b0;
         pend_lo       <= 1'b0;
         rem           <= '0;
         rd_valid_o    <= 1'b0;
         next_sample_o <= 1'b0;
      end else begin
         next_sample_o <= 1'b0;
         if (!data_ready_i) begin
            active     <= 1'b0;   // Window gone or not yet captured
            pend_lo    <= 1'b0;
            rd_valid_o <= 1'b0;
         end else if (!active) begin
            active        <= 1'b1;
            rem           <= total - 1'b1;
            next_sample_o <= 1'b1;
         end else if (sample_valid_i) begin
            rd_valid_o <= 1'b1;
            pend_lo    <= !cfg_i.ctrl.low_res;
         end else if (accept) begin
            if (pend_lo) begin
               pend_lo <= 1'b0;
            end else begin
               rd_valid_o <= 1'b0;
               if (rem != '0) begin
                  rem           <= rem - 1'b1;
                  next_sample_o <= 1'b1;
               end
            end
         end
      end
   end

   // Output byte only changes when empty or accepted
   always_ff @(posedge ADC_clk_sample) begin
      if (sample_valid_i) begin
         lo_q <= sample_i.bytes.lo;
         if (cfg_i.ctrl.low_res) begin
            rd_data_o.data <= sample_i.full.value[11:4];
            rd_data_o.last <= (rem == '0);
         end else begin
            rd_data_o.data <= sample_i.bytes.hi;
            rd_data_o.last <= 1'b0;
         end
      end else if (accept && pend_lo) begin
         rd_data_o.data <= lo_q;
         rd_data_o.last <= (rem == '0);
      end
   end

endmodule

// File: verilog/adc_reg_block.sv
module adc_reg_block (
   input  logic                          ADC_clk_sample,
   input  logic                          reset,
   input  logic [7:0]                    reg_address_i,
   input  logic [7:0]                    reg_datai_i,
   input  logic                          reg_write_i,
   input  logic                          reg_read_i,
   input  adc_capture_pkg::status_t      status_i,
   output logic [7:0]                    reg_datao_o,
   output adc_capture_pkg::capture_cfg_t cfg_o,
   output logic                          arm_o
);

   adc_capture_pkg::ctrl_reg_t ctrl_q;
   adc_capture_pkg::ctrl_reg_t ctrl_raw;
   adc_capture_pkg::ctrl_reg_t ctrl_wr;
   logic [adc_capture_pkg::SAMPLE_W-1:0] level_q;
   logic [7:0] presamples_q;
   logic [7:0] maxsamples_q;
   logic [7:0] downsample_q;
   logic [7:0] rd_mux;

   assign ctrl_raw = adc_capture_pkg::ctrl_reg_t'(reg_datai_i);

   // Stored control byte keeps neither the arm strobe nor reserved bits
   always_comb begin
      ctrl_wr          = ctrl_raw;
      ctrl_wr.arm      = 1'b0;
      ctrl_wr.reserved = '0;
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         ctrl_q       <= '0;
         level_q      <= '0;
         presamples_q <= '0;
         maxsamples_q <= '0;
         downsample_q <= '0;
         arm_o        <= 1'b0;
      end else begin
         arm_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               adc_capture_pkg::REG_CTRL: begin
                  ctrl_q <= ctrl_wr;
                  arm_o  <= ctrl_raw.arm;   // One-cycle arm pulse
               end
               adc_capture_pkg::REG_LEVEL_LO:   level_q[7:0]  <= reg_datai_i;
               adc_capture_pkg::REG_LEVEL_HI:   level_q[11:8] <= reg_datai_i[3:0];
               adc_capture_pkg::REG_PRESAMPLES: presamples_q  <= reg_datai_i;
               adc_capture_pkg::REG_MAXSAMPLES: maxsamples_q  <= reg_datai_i;
               adc_capture_pkg::REG_DOWNSAMPLE: downsample_q  <= reg_datai_i;
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (reg_address_i)
         adc_capture_pkg::REG_CTRL:       rd_mux = ctrl_q;
         adc_capture_pkg::REG_STATUS:     rd_mux = status_i;
         adc_capture_pkg::REG_LEVEL_LO:   rd_mux = level_q[7:0];
         adc_capture_pkg::REG_LEVEL_HI:   rd_mux = {4'h0, level_q[11:8]};
         adc_capture_pkg::REG_PRESAMPLES: rd_mux = presamples_q;
         adc_capture_pkg::REG_MAXSAMPLES: rd_mux = maxsamples_q;
         adc_capture_pkg::REG_DOWNSAMPLE: rd_mux = downsample_q;
         default:                         rd_mux = '0;
      endcase
   end

   // Read data is held until the next read strobe
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         reg_datao_o <= '0;
      else if (reg_read_i)
         reg_datao_o <= rd_mux;
   end

   assign cfg_o.ctrl       = ctrl_q;
   assign cfg_o.level      = level_q;
   assign cfg_o.presamples = presamples_q;
   assign cfg_o.maxsamples = maxsamples_q;
   assign cfg_o.downsample = downsample_q;

endmodule

// File: verilog/adc_sample_source.sv
module adc_sample_source (
   input  logic                                 ADC_clk_sample,
   input  logic                                 reset,
   input  logic [adc_capture_pkg::SAMPLE_W-1:0] adc_data_i,
   input  logic                                 ext_trigger_i,
   input  adc_capture_pkg::capture_cfg_t        cfg_i,
   input  logic                                 arm_i,
   output logic                                 strobe_o,
   output logic [adc_capture_pkg::SAMPLE_W-1:0] sample_o,
   output logic                                 ext_o
);

   logic [adc_capture_pkg::SAMPLE_W-1:0] test_cnt;
   logic [7:0] div_cnt;
   logic       div_hit;

   assign div_hit = (div_cnt == cfg_i.downsample);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         test_cnt <= '0;
         div_cnt  <= '0;
         strobe_o <= 1'b0;
      end else begin
         test_cnt <= test_cnt + 1'b1;   // Free running, wraps at 4096
         if (arm_i || div_hit)
            div_cnt <= '0;              // Arm restarts the divider phase
         else
            div_cnt <= div_cnt + 1'b1;
         strobe_o <= div_hit;
      end
   end

   // Sample and trigger pin are taken on the same edge as the strobe
   always_ff @(posedge ADC_clk_sample) begin
      sample_o <= cfg_i.ctrl.src_adc ? adc_data_i : test_cnt;
      ext_o    <= ext_trigger_i;
   end

endmodule

// File: verilog/adc_trigger_unit.sv
module adc_trigger_unit (
   input  logic                                 ADC_clk_sample,
   input  logic                                 reset,
   input  adc_capture_pkg::capture_cfg_t        cfg_i,
   input  logic                                 arm_i,
   input  logic                                 strobe_i,
   input  logic [adc_capture_pkg::SAMPLE_W-1:0] sample_i,
   input  logic                                 ext_i,
   input  logic                                 capture_done_i,
   output logic                                 armed_o,
   output logic                                 triggered_o,
   output logic                                 record_o,
   output logic                                 trig_hit_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_TRIG
   } state_t;

   state_t     state;
   logic [7:0] pre_cnt;
   logic       pre_done;
   logic       level_hit;
   logic       hit;

   assign pre_done  = (pre_cnt == cfg_i.presamples);
   assign level_hit = cfg_i.ctrl.trig_high ? (sample_i >= cfg_i.level)
                                           : (sample_i <= cfg_i.level);
   assign hit       = cfg_i.ctrl.trig_ext ? (ext_i == cfg_i.ctrl.trig_high) : level_hit;

   // Hit is only taken once the presamples are in the buffer
   assign trig_hit_o = (state == ST_WAIT) && strobe_i && pre_done && hit;

   assign armed_o  = (state != ST_IDLE);
   assign record_o = (state == ST_WAIT) || (state == ST_TRIG);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state       <= ST_IDLE;
         pre_cnt     <= '0;
         triggered_o <= 1'b0;
      end else if (arm_i) begin
         state       <= ST_WAIT;   // Re-arming restarts any capture
         pre_cnt     <= '0;
         triggered_o <= 1'b0;
      end else begin
         case (state)
            ST_WAIT: begin
               if (trig_hit_o) begin
                  triggered_o <= 1'b1;
                  state       <= capture_done_i ? ST_IDLE : ST_TRIG;
               end else if (strobe_i && !pre_done) begin
                  pre_cnt <= pre_cnt + 1'b1;
               end
            end
            ST_TRIG: if (capture_done_i) state <= ST_IDLE;
            default: ;
         endcase
      end
   end

endmodule

// File: verilog/openadc_capture_top.sv
module openadc_capture_top (
   input  logic                                 ADC_clk_sample,
   input  logic                                 reset,
   input  logic [adc_capture_pkg::SAMPLE_W-1:0] adc_data_i,
   input  logic                                 ext_trigger_i,
   input  logic [7:0]                           reg_address_i,
   input  logic [7:0]                           reg_datai_i,
   input  logic                                 reg_write_i,
   input  logic                                 reg_read_i,
   output logic [7:0]                           reg_datao_o,
   output adc_capture_pkg::rd_byte_t            rd_data_o,
   output logic                                 rd_valid_o,
   input  logic                                 rd_ready_i
);

   adc_capture_pkg::capture_cfg_t        cfg;
   adc_capture_pkg::status_t             status;
   adc_capture_pkg::sample_u             buf_sample;
   logic [adc_capture_pkg::SAMPLE_W-1:0] sample;
   logic arm;
   logic strobe;
   logic ext;
   logic armed;
   logic triggered;
   logic record;
   logic trig_hit;
   logic capture_done;
   logic data_ready;
   logic next_sample;
   logic sample_valid;
   logic rd_done;

   assign status.zero       = '0;
   assign status.data_ready = data_ready;
   assign status.triggered  = triggered;
   assign status.armed      = armed;

   adc_reg_block adc_reg_block_inst (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_datai_i    (reg_datai_i),
      .reg_write_i    (reg_write_i),
      .reg_read_i     (reg_read_i),
      .status_i       (status),
      .reg_datao_o    (reg_datao_o),
      .cfg_o          (cfg),
      .arm_o          (arm)
   );

   adc_sample_source adc_sample_source_inst (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .ext_trigger_i  (ext_trigger_i),
      .cfg_i          (cfg),
      .arm_i          (arm),
      .strobe_o       (strobe),
      .sample_o       (sample),
      .ext_o          (ext)
   );

   adc_trigger_unit adc_trigger_unit_inst (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg),
      .arm_i          (arm),
      .strobe_i       (strobe),
      .sample_i       (sample),
      .ext_i          (ext),
      .capture_done_i (capture_done),
      .armed_o        (armed),
      .triggered_o    (triggered),
      .record_o       (record),
      .trig_hit_o     (trig_hit)
   );

   adc_capture_buffer adc_capture_buffer_inst (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg),
      .arm_i          (arm),
      .strobe_i       (strobe),
      .sample_i       (sample),
      .record_i       (record),
      .trig_hit_i     (trig_hit),
      .next_sample_i  (next_sample),
      .rd_done_i      (rd_done),
      .capture_done_o (capture_done),
      .data_ready_o   (data_ready),
      .sample_o       (buf_sample),
      .sample_valid_o (sample_valid)
   );

   adc_readout adc_readout_inst (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg),
      .data_ready_i   (data_ready),
      .sample_i       (buf_sample),
      .sample_valid_i (sample_valid),
      .rd_ready_i     (rd_ready_i),
      .next_sample_o  (next_sample),
      .rd_done_o      (rd_done),
      .rd_data_o      (rd_data_o),
      .rd_valid_o     (rd_valid_o)
   );

endmodule
